/* dcache.f */
hw/dcache_pkg.sv
hw/dcache_if.sv
hw/dcache_req_side.sv
hw/dcache_arrays.sv
hw/dcache_controller.sv
hw/dcache_bus_port.sv
hw/dcache_align.sv
hw/dcache.sv
tests/dcache_mem_model.sv
tests/dcache_tb.sv

/* hw/dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache
    import dcache_pkg::*;
#(
    parameter int INDEX_BITS = 6
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   rd_req_valid,
    output logic   rd_req_ready,
    input  addr_t  rd_req_address,
    output logic   rd_dp_valid,
    input  logic   rd_dp_ready,
    output dword_t rd_dp_read_data,
    input  logic   wr_req_valid,
    output logic   wr_req_ready,
    input  addr_t  wr_req_address,
    input  dword_t wr_req_data,
    input  logic   wr_size_in,
    output addr_t  virt_addr,
    input  addr_t  phys_addr,
    input  logic   tlb_hit,
    input  logic   tlb_pcd,
    output logic   page_fault,
    output logic   mem_req,
    output logic   mem_rd_wr,
    output addr_t  mem_addr,
    output word_t  mem_wdata,
    input  logic   grant_in,
    input  logic   mem_data_valid,
    input  word_t  mem_rdata
);
    logic    accept_rd;
    logic    accept_wr;
    logic    next_line;
    logic    is_write;
    dword_t  wdata;
    logic    wsize;
    offset_t byte_offset;
    logic    needs_second;
    logic    load_first;
    logic    deliver;

    lookup_if #(.INDEX_BITS(INDEX_BITS)) lk ();
    bus_cmd_if bus ();

    dcache_req_side u_req_side (
        .clk            (clk),
        .arst_n         (arst_n),
        .rd_req_valid   (rd_req_valid),
        .rd_req_address (rd_req_address),
        .wr_req_valid   (wr_req_valid),
        .wr_req_address (wr_req_address),
        .wr_req_data    (wr_req_data),
        .wr_size_in     (wr_size_in),
        .accept_rd      (accept_rd),
        .accept_wr      (accept_wr),
        .next_line      (next_line),
        .rd_req_ready   (rd_req_ready),
        .wr_req_ready   (wr_req_ready),
        .virt_addr      (virt_addr),
        .is_write       (is_write),
        .wdata          (wdata),
        .wsize          (wsize),
        .byte_offset    (byte_offset),
        .needs_second   (needs_second)
    );

    dcache_arrays #(.INDEX_BITS(INDEX_BITS)) u_arrays (
        .clk    (clk),
        .arst_n (arst_n),
        .lk     (lk.arrays)
    );

    dcache_controller #(.INDEX_BITS(INDEX_BITS)) u_controller (
        .clk          (clk),
        .arst_n       (arst_n),
        .rd_req_valid (rd_req_valid),
        .wr_req_valid (wr_req_valid),
        .is_write     (is_write),
        .needs_second (needs_second),
        .wdata        (wdata),
        .wsize        (wsize),
        .phys_addr    (phys_addr),
        .tlb_hit      (tlb_hit),
        .tlb_pcd      (tlb_pcd),
        .rd_dp_ready  (rd_dp_ready),
        .accept_rd    (accept_rd),
        .accept_wr    (accept_wr),
        .next_line    (next_line),
        .page_fault   (page_fault),
        .load_first   (load_first),
        .deliver      (deliver),
        .lk           (lk.controller),
        .bus          (bus.controller)
    );

    dcache_bus_port u_bus_port (
        .clk            (clk),
        .arst_n         (arst_n),
        .cmd            (bus.port),
        .grant_in       (grant_in),
        .mem_data_valid (mem_data_valid),
        .mem_rdata      (mem_rdata),
        .mem_req        (mem_req),
        .mem_rd_wr      (mem_rd_wr),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata)
    );

    // current line as chosen by the controller
    dcache_align u_align (
        .clk             (clk),
        .arst_n          (arst_n),
        .line            (lk.line_in),
        .load_first      (load_first),
        .deliver         (deliver),
        .byte_offset     (byte_offset),
        .rd_dp_ready     (rd_dp_ready),
        .rd_dp_valid     (rd_dp_valid),
        .rd_dp_read_data (rd_dp_read_data)
    );

endmodule

`default_nettype wire

/* hw/dcache_align.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_align
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  dword_t  line,
    input  logic    load_first,
    input  logic    deliver,
    input  offset_t byte_offset,
    input  logic    rd_dp_ready,
    output logic    rd_dp_valid,
    output dword_t  rd_dp_read_data
);
    dword_t        first_q;
    dword_t        low;
    logic [127:0]  both;
    dword_t        shifted;

    // aligned reads use one line only
    assign low     = (byte_offset == 3'd0) ? line : first_q;
    assign both    = {line, low};
    assign shifted = both[{byte_offset, 3'b000} +: 64];

    always_ff @(posedge clk) begin
        if (load_first) begin
            first_q <= line;
        end
        if (deliver) begin
            rd_dp_read_data <= shifted;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_dp_valid <= 1'b0;
        end else if (deliver) begin
            rd_dp_valid <= 1'b1;
        end else if (rd_dp_ready) begin
            rd_dp_valid <= 1'b0;
        end
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        (rd_dp_valid && !rd_dp_ready) |=> (rd_dp_valid && $stable(rd_dp_read_data))
    ) else $error("read data changed under back-pressure");

endmodule

`default_nettype wire

/* hw/dcache_arrays.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_arrays
    import dcache_pkg::*;
#(
    parameter int INDEX_BITS = 6
) (
    input  logic  clk,
    input  logic  arst_n,
    lookup_if.arrays lk
);
    localparam int SETS  = 2 ** INDEX_BITS;
    localparam int TAG_W = ADDR_W - INDEX_BITS - 3;

    logic [TAG_W-1:0] tag_mem [SETS];
    dword_t           data_mem [SETS];
    logic [SETS-1:0]  valid_q;

    logic [TAG_W-1:0] tag_rd;
    logic             valid_rd;

    always_ff @(posedge clk) begin
        if (lk.write) begin
            tag_mem[lk.index]  <= lk.tag;
            data_mem[lk.index] <= lk.line_in;
        end
        tag_rd      <= tag_mem[lk.index];
        lk.line_out <= data_mem[lk.index];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q  <= '0;
            valid_rd <= 1'b0;
        end else begin
            if (lk.write) begin
                valid_q[lk.index] <= lk.valid_in;
            end
            valid_rd <= valid_q[lk.index];
        end
    end

    // tag from the current cycle against last cycle's read
    assign lk.hit = valid_rd && (tag_rd == lk.tag);

    a_write_index_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        lk.write |-> !$isunknown(lk.index)
    ) else $error("array write with unknown index");

endmodule

`default_nettype wire

/* hw/dcache_bus_port.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_bus_port
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    bus_cmd_if.port cmd,
    input  logic  grant_in,
    input  logic  mem_data_valid,
    input  word_t mem_rdata,
    output logic  mem_req,
    output logic  mem_rd_wr,
    output addr_t mem_addr,
    output word_t mem_wdata
);
    logic   active_q;
    logic   granted_q;
    logic   beat_q;
    logic   two_q;
    addr_t  addr_q;
    dword_t wdata_q;
    word_t  acc_q;
    dword_t line_q;
    logic   beat_end;
    logic   last_beat;

    assign beat_end  = active_q && granted_q && mem_data_valid;
    assign last_beat = beat_q || !two_q;

    assign mem_req   = active_q;
    assign mem_addr  = addr_q;
    assign mem_wdata = beat_q ? wdata_q[63:32] : wdata_q[31:0];

    assign cmd.done = beat_end && last_beat;
    assign cmd.line = line_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active_q  <= 1'b0;
            granted_q <= 1'b0;
            beat_q    <= 1'b0;
        end else if (cmd.start) begin
            active_q  <= 1'b1;
            granted_q <= 1'b0;
            beat_q    <= 1'b0;
        end else begin
            if (active_q && grant_in) begin
                granted_q <= 1'b1;
            end
            if (beat_end) begin
                if (last_beat) begin
                    active_q  <= 1'b0;
                    granted_q <= 1'b0;
                end else begin
                    beat_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.start) begin
            addr_q    <= cmd.paddr;
            wdata_q   <= cmd.wdata;
            two_q     <= cmd.two_beats;
            mem_rd_wr <= cmd.rd_wr;
        end else if (beat_end) begin
            // first read word waits in the accumulator
            if (!beat_q && !mem_rd_wr) begin
                acc_q <= mem_rdata;
            end
            if (last_beat && !mem_rd_wr) begin
                line_q <= {mem_rdata, acc_q};
            end
            if (!last_beat) begin
                addr_q <= addr_q + addr_t'(4);
            end
        end
    end

    a_data_after_grant: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_data_valid |-> (active_q && granted_q)
    ) else $error("mem_data_valid without a grant");

endmodule

`default_nettype wire

/* hw/dcache_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_controller
    import dcache_pkg::*;
#(
    parameter int INDEX_BITS = 6
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   rd_req_valid,
    input  logic   wr_req_valid,
    input  logic   is_write,
    input  logic   needs_second,
    input  dword_t wdata,
    input  logic   wsize,
    input  addr_t  phys_addr,
    input  logic   tlb_hit,
    input  logic   tlb_pcd,
    input  logic   rd_dp_ready,
    output logic   accept_rd,
    output logic   accept_wr,
    output logic   next_line,
    output logic   page_fault,
    output logic   load_first,
    output logic   deliver,
    lookup_if.controller  lk,
    bus_cmd_if.controller bus
);
    localparam int TAG_W = ADDR_W - INDEX_BITS - 3;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    addr_t       pa_q;
    addr_t       cur_pa;
    logic        pcd_q;
    logic        second_q;
    logic        filled_q;
    logic        translating;
    logic        usable_hit;
    logic        line_ready;
    logic        last_line;
    logic        wr_start;
    logic        fill_start;

    assign translating = (state_q == ST_LOOKUP) || (state_q == ST_SECOND);

    // set index straight from the TLB so the read lines up with compare
    assign cur_pa   = translating ? phys_addr : pa_q;
    assign lk.index = cur_pa[INDEX_BITS+2:3];
    assign lk.tag   = pa_q[ADDR_W-1 -: TAG_W];

    // fresh bus line after a fill and the array line otherwise
    assign lk.line_in  = filled_q ? bus.line : lk.line_out;
    assign lk.valid_in = (state_q == ST_INSTALL);

    assign usable_hit = lk.hit && !pcd_q;
    assign line_ready = ((state_q == ST_COMPARE) && !is_write && usable_hit)
                     || (state_q == ST_INSTALL);
    assign last_line  = second_q || !needs_second;
    assign load_first = line_ready && !last_line;
    assign deliver    = line_ready && last_line;

    // install cacheable fills, drop the line on a write hit
    assign lk.write = ((state_q == ST_INSTALL) && !pcd_q)
                   || ((state_q == ST_COMPARE) && is_write && lk.hit);

    assign accept_rd  = (state_q == ST_IDLE);
    assign accept_wr  = (state_q == ST_IDLE) && !rd_req_valid;
    assign next_line  = second_q;
    assign page_fault = (state_q == ST_FAULT);

    assign fill_start    = (state_q == ST_FILL_REQ);
    assign wr_start      = (state_q == ST_WRITE_REQ);
    assign bus.start     = fill_start || wr_start;
    assign bus.rd_wr     = wr_start;
    assign bus.paddr     = wr_start ? pa_q : {pa_q[ADDR_W-1:3], 3'b000};
    assign bus.wdata     = wdata;
    assign bus.two_beats = fill_start || wsize;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (rd_req_valid || wr_req_valid) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP, ST_SECOND: begin
                state_d = tlb_hit ? ST_COMPARE : ST_FAULT;
            end
            ST_COMPARE: begin
                if (is_write) begin
                    state_d = ST_WRITE_REQ;
                end else if (usable_hit) begin
                    state_d = last_line ? ST_DELIVER : ST_SECOND;
                end else begin
                    state_d = ST_FILL_REQ;
                end
            end
            ST_FILL_REQ:   state_d = ST_FILL_WAIT;
            ST_FILL_WAIT: begin
                if (bus.done) begin
                    state_d = ST_INSTALL;
                end
            end
            ST_INSTALL:    state_d = last_line ? ST_DELIVER : ST_SECOND;
            ST_WRITE_REQ:  state_d = ST_WRITE_WAIT;
            ST_WRITE_WAIT: begin
                if (bus.done) begin
                    state_d = ST_IDLE;
                end
            end
            ST_DELIVER: begin
                if (rd_dp_ready) begin
                    state_d = ST_IDLE;
                end
            end
            default:       state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= ST_IDLE;
            second_q <= 1'b0;
            filled_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE) begin
                second_q <= 1'b0;
            end else if (load_first) begin
                second_q <= 1'b1;
            end
            if (translating) begin
                filled_q <= 1'b0;
            end else if ((state_q == ST_FILL_WAIT) && bus.done) begin
                filled_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (translating) begin
            pa_q  <= phys_addr;
            pcd_q <= tlb_pcd;
        end
    end

    // a fault ends the request with the bus port idle
    a_fault_no_bus: assert property (
        @(posedge clk) disable iff (!arst_n)
        page_fault |-> (!bus.start && !bus.done)
    ) else $error("bus active during a page fault");

endmodule

`default_nettype wire

/* hw/dcache_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface lookup_if
    import dcache_pkg::*;
#(
    parameter int INDEX_BITS = 6
);
    localparam int TAG_W = ADDR_W - INDEX_BITS - 3;

    logic [INDEX_BITS-1:0] index;
    logic [TAG_W-1:0]      tag;
    logic                  write;
    logic                  valid_in;
    dword_t                line_in;
    dword_t                line_out;
    logic                  hit;

    modport controller (
        output index, tag, write, valid_in, line_in,
        input  line_out, hit
    );

    modport arrays (
        input  index, tag, write, valid_in, line_in,
        output line_out, hit
    );
endinterface

interface bus_cmd_if
    import dcache_pkg::*;
;
    logic   start;
    logic   rd_wr;
    addr_t  paddr;
    dword_t wdata;
    logic   two_beats;
    logic   done;
    dword_t line;

    modport controller (
        output start, rd_wr, paddr, wdata, two_beats,
        input  done, line
    );

    modport port (
        input  start, rd_wr, paddr, wdata, two_beats,
        output done, line
    );
endinterface

`default_nettype wire

/* hw/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int LINE_BYTES = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [31:0]       word_t;
    typedef logic [63:0]       dword_t;
    typedef logic [2:0]        offset_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_FILL_REQ,
        ST_FILL_WAIT,
        ST_INSTALL,
        ST_COMPARE,
        ST_SECOND,
        ST_WRITE_REQ,
        ST_WRITE_WAIT,
        ST_DELIVER,
        ST_FAULT
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hw/dcache_req_side.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_req_side
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    rd_req_valid,
    input  addr_t   rd_req_address,
    input  logic    wr_req_valid,
    input  addr_t   wr_req_address,
    input  dword_t  wr_req_data,
    input  logic    wr_size_in,
    input  logic    accept_rd,
    input  logic    accept_wr,
    input  logic    next_line,
    output logic    rd_req_ready,
    output logic    wr_req_ready,
    output addr_t   virt_addr,
    output logic    is_write,
    output dword_t  wdata,
    output logic    wsize,
    output offset_t byte_offset,
    output logic    needs_second
);
    addr_t addr_q;
    logic  take_rd;
    logic  take_wr;

    // controller levels open the handshake
    assign rd_req_ready = accept_rd;
    assign wr_req_ready = accept_wr;
    assign take_rd      = accept_rd && rd_req_valid;
    assign take_wr      = accept_wr && wr_req_valid;

    always_ff @(posedge clk) begin
        if (take_rd) begin
            addr_q <= rd_req_address;
        end else if (take_wr) begin
            addr_q <= wr_req_address;
            wdata  <= wr_req_data;
            wsize  <= wr_size_in;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            is_write <= 1'b0;
        end else if (take_rd) begin
            is_write <= 1'b0;
        end else if (take_wr) begin
            is_write <= 1'b1;
        end
    end

    // second pass looks at the following line
    assign virt_addr    = next_line ? addr_q + addr_t'(LINE_BYTES) : addr_q;
    assign byte_offset  = addr_q[2:0];
    assign needs_second = |addr_q[2:0];

endmodule

`default_nettype wire

/* tests/dcache_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model
    import dcache_pkg::*;
#(
    parameter logic [31:0] SEED = 32'd68
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  mem_req,
    input  logic  mem_rd_wr,
    input  addr_t mem_addr,
    input  word_t mem_wdata,
    output logic  grant_in,
    output logic  mem_data_valid,
    output word_t mem_rdata,
    output int    write_beats,
    output addr_t last_wr_addr
);
    logic [7:0]  bytes [addr_t];
    logic [31:0] rng_q;
    logic        granted_q;
    int          wait_q;

    function automatic logic [7:0] pattern_byte(input addr_t a);
        return (a[7:0] * 8'd37) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] fetch_byte(input addr_t a);
        if (bytes.exists(a)) begin
            return bytes[a];
        end
        return pattern_byte(a);
    endfunction

    function automatic int next_delay();
        rng_q = rng_q ^ (rng_q << 13);
        rng_q = rng_q ^ (rng_q >> 17);
        rng_q = rng_q ^ (rng_q << 5);
        return int'(rng_q % 4);
    endfunction

    // one beat per valid pulse, random gaps before grant and each beat
    always @(negedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rng_q          = SEED;
            granted_q      = 1'b0;
            wait_q         = 0;
            grant_in       <= 1'b0;
            mem_data_valid <= 1'b0;
            mem_rdata      <= '0;
            write_beats    <= 0;
            last_wr_addr   <= '0;
        end else if (mem_data_valid) begin
            mem_data_valid <= 1'b0;
            wait_q = next_delay();
        end else if (!mem_req) begin
            granted_q = 1'b0;
            grant_in  <= 1'b0;
            wait_q = next_delay();
        end else if (!granted_q) begin
            if (wait_q == 0) begin
                grant_in  <= 1'b1;
                granted_q = 1'b1;
                wait_q = next_delay();
            end else begin
                wait_q = wait_q - 1;
            end
        end else begin
            grant_in <= 1'b0;
            if (wait_q == 0) begin
                if (mem_rd_wr) begin
                    for (int i = 0; i < 4; i++) begin
                        bytes[mem_addr + addr_t'(i)] = mem_wdata[8*i +: 8];
                    end
                    write_beats  <= write_beats + 1;
                    last_wr_addr <= mem_addr;
                end else begin
                    mem_rdata <= {fetch_byte(mem_addr + 3), fetch_byte(mem_addr + 2),
                                  fetch_byte(mem_addr + 1), fetch_byte(mem_addr)};
                end
                mem_data_valid <= 1'b1;
            end else begin
                wait_q = wait_q - 1;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
;
    localparam int N_OPS       = 300;
    localparam int CYCLE_LIMIT = N_OPS * 40;
    localparam addr_t BASE     = 32'h0004_0000;

    logic   clk;
    logic   arst_n;
    logic   rd_req_valid;
    logic   rd_req_ready;
    addr_t  rd_req_address;
    logic   rd_dp_valid;
    logic   rd_dp_ready;
    dword_t rd_dp_read_data;
    logic   wr_req_valid;
    logic   wr_req_ready;
    addr_t  wr_req_address;
    dword_t wr_req_data;
    logic   wr_size_in;
    addr_t  virt_addr;
    addr_t  phys_addr;
    logic   tlb_hit;
    logic   tlb_pcd;
    logic   page_fault;
    logic   mem_req;
    logic   mem_rd_wr;
    addr_t  mem_addr;
    word_t  mem_wdata;
    logic   grant_in;
    logic   mem_data_valid;
    word_t  mem_rdata;
    int     write_beats;
    addr_t  last_wr_addr;

    logic [7:0]  ref_mem [addr_t];
    logic [31:0] rng_state;
    dword_t      exp_data;
    logic        req_seen;
    logic        fault_seen;
    logic        valid_seen;
    int          cycle_count;
    int          op_count;

    // TLB model flips bit 20 and marks fields 15 and 14
    assign phys_addr = virt_addr ^ 32'h0010_0000;
    assign tlb_hit   = (virt_addr[15:12] != 4'hf);
    assign tlb_pcd   = (virt_addr[15:12] == 4'he);

    dcache #(.INDEX_BITS(6)) u_dcache (.*);

    dcache_mem_model #(.SEED(32'd68)) u_mem_model (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] rand32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [7:0] ref_byte(input addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return (a[7:0] * 8'd37) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    // 8 bytes from the physical address with the lowest byte first
    function automatic dword_t expected_read(input addr_t pa);
        dword_t d;
        for (int i = 0; i < 8; i++) begin
            d[8*i +: 8] = ref_byte(pa + addr_t'(i));
        end
        return d;
    endfunction

    task automatic report_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic tick();
        @(negedge clk);
        if (mem_req) begin
            req_seen = 1'b1;
        end
        if (page_fault) begin
            fault_seen = 1'b1;
        end
        if (rd_dp_valid) begin
            valid_seen = 1'b1;
        end
        rd_dp_ready = (rand32() % 3) != 0;
    endtask

    // mode 1 must hit, mode 2 must go to the bus
    task automatic read_and_check(input addr_t va, input int mode);
        logic fault;
        fault          = (va[15:12] == 4'hf);
        exp_data       = expected_read(va ^ 32'h0010_0000);
        rd_req_address = va;
        rd_req_valid   = 1'b1;
        req_seen       = 1'b0;
        fault_seen     = 1'b0;
        valid_seen     = 1'b0;
        @(negedge clk);
        rd_req_valid = 1'b0;
        do begin
            tick();
        end while (!rd_req_ready);
        assert (fault_seen == fault && valid_seen == !fault)
            else report_error($sformatf("read %h fault %b valid %b", va, fault_seen, valid_seen));
        assert (!(fault && req_seen)) else report_error($sformatf("bus used on fault %h", va));
        assert (!(mode == 1 && req_seen)) else report_error($sformatf("hit read %h used bus", va));
        assert (!(mode == 2 && !req_seen)) else report_error($sformatf("read %h skipped bus", va));
        op_count++;
    endtask

    task automatic write_and_check(input addr_t va, input dword_t data, input logic size64);
        logic  fault;
        addr_t pa;
        int    beats_before;
        fault = (va[15:12] == 4'hf);
        pa    = va ^ 32'h0010_0000;
        if (!fault) begin
            for (int i = 0; i < (size64 ? 8 : 4); i++) begin
                ref_mem[pa + addr_t'(i)] = data[8*i +: 8];
            end
        end
        beats_before   = write_beats;
        wr_req_address = va;
        wr_req_data    = data;
        wr_size_in     = size64;
        wr_req_valid   = 1'b1;
        req_seen       = 1'b0;
        fault_seen     = 1'b0;
        @(negedge clk);
        wr_req_valid = 1'b0;
        do begin
            tick();
        end while (!wr_req_ready);
        tick();
        assert (fault_seen == fault) else report_error($sformatf("write %h fault mismatch", va));
        if (fault) begin
            assert (!req_seen && write_beats == beats_before)
                else report_error($sformatf("bus used on faulting write %h", va));
        end else begin
            assert (write_beats - beats_before == (size64 ? 2 : 1))
                else report_error($sformatf("write %h gave %0d beats", va,
                                            write_beats - beats_before));
            assert (last_wr_addr == pa + (size64 ? 32'd4 : 32'd0))
                else report_error($sformatf("write beat address %h", last_wr_addr));
        end
        op_count++;
    endtask

    function automatic addr_t random_addr();
        logic [31:0] r;
        logic [3:0]  field;
        r = rand32();
        case (r[2:0])
            3'd6:    field = 4'he;
            3'd7:    field = 4'hf;
            default: field = {3'b000, r[3]};
        endcase
        return BASE | (addr_t'(field) << 12) | addr_t'(r[15:8]);
    endfunction

    always @(negedge clk) begin
        if (arst_n && rd_dp_valid) begin
            assert (rd_dp_read_data === exp_data)
                else report_error($sformatf("read data %h, expected %h",
                                            rd_dp_read_data, exp_data));
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $fatal(1);
        end
    end

    initial begin
        addr_t a;
        logic  sz;
        clk = 1'b0;
        arst_n = 1'b0;
        rd_req_valid = 1'b0;
        rd_req_address = '0;
        rd_dp_ready = 1'b0;
        wr_req_valid = 1'b0;
        wr_req_address = '0;
        wr_req_data = '0;
        wr_size_in = 1'b0;
        rng_state = 32'd68;
        cycle_count = 0;
        op_count = 0;
        exp_data = '0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        read_and_check(BASE + 32'h000, 2);
        read_and_check(BASE + 32'h000, 1);
        read_and_check(BASE + 32'h023, 0);
        read_and_check(BASE + 32'h1017, 0);
        write_and_check(BASE + 32'h008, 64'h1122_3344_5566_7788, 1'b1);
        read_and_check(BASE + 32'h004, 0);
        write_and_check(BASE + 32'h010, 64'h0000_0000_a5a5_c3c3, 1'b0);
        read_and_check(BASE + 32'h00c, 0);
        read_and_check(BASE + 32'he020, 2);
        read_and_check(BASE + 32'he020, 2);
        read_and_check(BASE + 32'hf005, 0);
        write_and_check(BASE + 32'hf010, 64'hdead_beef_0bad_f00d, 1'b1);

        // mixed traffic with aliasing sets
        while (op_count < N_OPS) begin
            a = random_addr();
            if (rand32() % 3 == 0) begin
                sz = (rand32() % 2) != 0;
                a  = sz ? {a[31:3], 3'b000} : {a[31:2], 2'b00};
                write_and_check(a, {rand32(), rand32()}, sz);
            end else begin
                read_and_check(a, (a[15:12] == 4'he) ? 2 : 0);
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
